//--- design/arp_dma_pkg.sv
// Stream beat and word decoding types; import into any module that handles beats
`default_nettype none

`include "arp_dma_macros.svh"

package arp_dma_pkg;

   // One stream beat as stored in the FIFOs
   typedef struct packed {
      logic [`ARP_DMA_DATA_W-1:0] data;
      logic [`ARP_DMA_KEEP_W-1:0] keep;
      logic [`ARP_DMA_USER_W-1:0] user;
      logic                       last;
   } axis_beat_t;

   // User word, raw or split into port and length
   typedef union packed {
      logic [`ARP_DMA_USER_W-1:0] raw;
      struct packed {
         logic [`ARP_DMA_USER_W-25:0] spare;
         logic [7:0]                  src_port;
         logic [15:0]                 len;
      } fields;
   } tuser_u;

   // Data word, raw or as the metadata beat
   typedef union packed {
      logic [`ARP_DMA_DATA_W-1:0] raw;
      struct packed {
         logic [79:0] pad;
         logic [31:0] size;
         logic [31:0] offset;
         logic [31:0] magic;
         // First ten bytes of the ARP second beat
         logic [79:0] arp_tail;
      } meta;
   } tdata_u;

endpackage

`default_nettype wire

//--- design/arp_dma_steer.sv
// Packet classifier: absorbs DMA packets, serves ARP requests with DMA data, passes the rest
`timescale 1ns/100ps
`default_nettype none

`include "arp_dma_macros.svh"

module arp_dma_steer import arp_dma_pkg::*; (
   input  logic        axis_aclk,
   input  logic        axis_resetn,
   axis_beat_if.snk    in_q,
   axis_beat_if.src    dma_wr,
   axis_beat_if.snk    dma_rd,
   input  logic [31:0] size,
   input  logic [31:0] chunk_len,
   input  logic [31:0] offset,
   output logic        chunk_taken,
   output axis_beat_t  m_beat,
   output logic        m_valid,
   input  logic        m_ready
);

   localparam logic [2:0] st_idle        = 3'd0;
   localparam logic [2:0] st_absorb      = 3'd1;
   localparam logic [2:0] st_arp_meta    = 3'd2;
   localparam logic [2:0] st_arp_payload = 3'd3;
   localparam logic [2:0] st_arp_drain   = 3'd4;
   localparam logic [2:0] st_pass        = 3'd5;

   logic [2:0]  state;
   logic [2:0]  next_state;
   logic        drain_pending;
   logic        drain_next;

   tuser_u      head_user;
   tuser_u      arp_user;
   tdata_u      meta_data;
   logic [7:0]  src_port;
   logic [31:0] frame_len;
   logic        is_dma;
   logic        is_arp;
   logic        serve_arp;

   assign head_user.raw = in_q.beat.user;
   assign src_port      = head_user.fields.src_port;

   // Exactly one port bit set, and it lies in the DMA mask
   assign is_dma    = $onehot(src_port) && ((src_port & ~`ARP_DMA_PORT_MASK) == 8'h00);
   assign is_arp    = (in_q.beat.data[111:96] == `ARP_DMA_ETHERTYPE_ARP);
   assign serve_arp = is_arp && !in_q.beat.last && dma_rd.valid && (chunk_len != 32'd0);
   assign frame_len = chunk_len + `ARP_DMA_HDR_BYTES;

   // Absorbed packets go to the buffer untouched
   assign dma_wr.beat = in_q.beat;

   always_comb begin
      arp_user            = head_user;
      arp_user.fields.len = frame_len[15:0];
   end

   always_comb begin
      meta_data.raw           = '0;
      meta_data.meta.size     = size;
      meta_data.meta.offset   = offset;
      meta_data.meta.magic    = `ARP_DMA_MAGIC;
      meta_data.meta.arp_tail = in_q.beat.data[79:0];
   end

   always_comb begin
      next_state   = state;
      drain_next   = drain_pending;
      m_beat       = in_q.beat;
      m_valid      = 1'b0;
      in_q.ready   = 1'b0;
      dma_wr.valid = 1'b0;
      dma_rd.ready = 1'b0;
      chunk_taken  = 1'b0;

      case (state)
         st_idle: begin
            // First beat of each packet is handled right here
            if (in_q.valid) begin
               if (is_dma) begin
                  dma_wr.valid = 1'b1;
                  in_q.ready   = dma_wr.ready;
                  if (dma_wr.ready && !in_q.beat.last) begin
                     next_state = st_absorb;
                  end
               end else if (serve_arp) begin
                  m_beat.user = arp_user.raw;
                  m_valid     = 1'b1;
                  in_q.ready  = m_ready;
                  if (m_ready) begin
                     next_state = st_arp_meta;
                  end
               end else begin
                  m_valid    = 1'b1;
                  in_q.ready = m_ready;
                  if (m_ready && !in_q.beat.last) begin
                     next_state = st_pass;
                  end
               end
            end
         end

         st_absorb: begin
            dma_wr.valid = in_q.valid;
            in_q.ready   = dma_wr.ready;
            if (in_q.valid && dma_wr.ready && in_q.beat.last) begin
               next_state = st_idle;
            end
         end

         st_arp_meta: begin
            // Second ARP beat becomes the metadata beat
            m_beat.data = meta_data.raw;
            m_beat.keep = '1;
            m_beat.user = '0;
            m_beat.last = 1'b0;
            m_valid     = in_q.valid;
            in_q.ready  = m_ready;
            if (in_q.valid && m_ready) begin
               chunk_taken = 1'b1;
               drain_next  = !in_q.beat.last;
               next_state  = st_arp_payload;
            end
         end

         st_arp_payload: begin
            m_beat       = dma_rd.beat;
            m_valid      = dma_rd.valid;
            dma_rd.ready = m_ready;
            if (dma_rd.valid && m_ready && dma_rd.beat.last) begin
               next_state = drain_pending ? st_arp_drain : st_idle;
            end
         end

         st_arp_drain: begin
            // Rest of the ARP request is dropped
            in_q.ready = 1'b1;
            if (in_q.valid && in_q.beat.last) begin
               next_state = st_idle;
            end
         end

         st_pass: begin
            m_valid    = in_q.valid;
            in_q.ready = m_ready;
            if (in_q.valid && m_ready && in_q.beat.last) begin
               next_state = st_idle;
            end
         end

         default: begin
            next_state = st_idle;
         end
      endcase
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         state         <= st_idle;
         drain_pending <= 1'b0;
      end else begin
         state         <= next_state;
         drain_pending <= drain_next;
      end
   end

endmodule

`default_nettype wire

//--- design/arp_dma_top.sv
// Top level of the ARP/DMA steering block; plain stream ports, FIFOs, steering and counters
`timescale 1ns/100ps
`default_nettype none

`include "arp_dma_macros.svh"

module arp_dma_top import arp_dma_pkg::*; (
   input  logic                       axis_aclk,
   input  logic                       axis_resetn,

   input  logic [`ARP_DMA_DATA_W-1:0] s_axis_tdata,
   input  logic [`ARP_DMA_KEEP_W-1:0] s_axis_tkeep,
   input  logic [`ARP_DMA_USER_W-1:0] s_axis_tuser,
   input  logic                       s_axis_tvalid,
   output logic                       s_axis_tready,
   input  logic                       s_axis_tlast,

   output logic [`ARP_DMA_DATA_W-1:0] m_axis_tdata,
   output logic [`ARP_DMA_KEEP_W-1:0] m_axis_tkeep,
   output logic [`ARP_DMA_USER_W-1:0] m_axis_tuser,
   output logic                       m_axis_tvalid,
   input  logic                       m_axis_tready,
   output logic                       m_axis_tlast,

   input  logic [31:0]                cfg_size,
   input  logic                       counters_clear,
   output logic [31:0]                pkt_in_count,
   output logic [31:0]                pkt_out_count
);

   axis_beat_if s_in ();
   axis_beat_if in_q ();
   axis_beat_if dma_wr ();
   axis_beat_if dma_rd ();

   axis_beat_t  m_beat;
   logic        m_valid;
   logic        in_nearly_full;
   logic        chunk_taken;
   logic        in_eop;
   logic        out_eop;
   logic [31:0] size;
   logic [31:0] offset;
   logic [31:0] chunk_len;

   // Slave port into the input queue, held off a few slots early
   assign s_in.beat.data = s_axis_tdata;
   assign s_in.beat.keep = s_axis_tkeep;
   assign s_in.beat.user = s_axis_tuser;
   assign s_in.beat.last = s_axis_tlast;
   assign s_axis_tready  = s_in.ready & ~in_nearly_full;
   assign s_in.valid     = s_axis_tvalid & s_axis_tready;

   assign m_axis_tdata  = m_beat.data;
   assign m_axis_tkeep  = m_beat.keep;
   assign m_axis_tuser  = m_beat.user;
   assign m_axis_tlast  = m_beat.last;
   assign m_axis_tvalid = m_valid;

   assign in_eop  = s_axis_tvalid & s_axis_tready & s_axis_tlast;
   assign out_eop = m_valid & m_axis_tready & m_beat.last;

   packet_fifo #(.depth_bits(`ARP_DMA_FIFO_DEPTH_BITS)) input_fifo (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .wr          (s_in.snk),
      .rd          (in_q.src),
      .nearly_full (in_nearly_full)
   );

   packet_fifo #(.depth_bits(`ARP_DMA_FIFO_DEPTH_BITS)) dma_buffer (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .wr          (dma_wr.snk),
      .rd          (dma_rd.src),
      .nearly_full ()
   );

   chunk_tracker chunk_tracker_i (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .cfg_size    (cfg_size),
      .chunk_taken (chunk_taken),
      .size        (size),
      .offset      (offset),
      .chunk_len   (chunk_len)
   );

   arp_dma_steer arp_dma_steer_i (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .in_q        (in_q.snk),
      .dma_wr      (dma_wr.src),
      .dma_rd      (dma_rd.snk),
      .size        (size),
      .chunk_len   (chunk_len),
      .offset      (offset),
      .chunk_taken (chunk_taken),
      .m_beat      (m_beat),
      .m_valid     (m_valid),
      .m_ready     (m_axis_tready)
   );

   packet_counters packet_counters_i (
      .axis_aclk      (axis_aclk),
      .axis_resetn    (axis_resetn),
      .counters_clear (counters_clear),
      .in_eop         (in_eop),
      .out_eop        (out_eop),
      .pkt_in_count   (pkt_in_count),
      .pkt_out_count  (pkt_out_count)
   );

endmodule

`default_nettype wire

//--- design/axis_beat_if.sv
// Valid/ready beat stream between the internal blocks; src drives beats, snk accepts them
`timescale 1ns/100ps
`default_nettype none

interface axis_beat_if;

   arp_dma_pkg::axis_beat_t beat;
   logic                    valid;
   logic                    ready;

   // Beat moves on an edge with valid and ready both high
   modport src (
      output beat,
      output valid,
      input  ready
   );

   modport snk (
      input  beat,
      input  valid,
      output ready
   );

endinterface

`default_nettype wire

//--- design/chunk_tracker.sv
// Tracks the DMA transfer size and offset and gives the length of the next chunk
`timescale 1ns/100ps
`default_nettype none

`include "arp_dma_macros.svh"

module chunk_tracker (
   input  logic        axis_aclk,
   input  logic        axis_resetn,
   input  logic [31:0] cfg_size,
   input  logic        chunk_taken,
   output logic [31:0] size,
   output logic [31:0] offset,
   output logic [31:0] chunk_len
);

   logic [31:0] remaining;

   assign remaining = size - offset;
   assign chunk_len = (remaining < `ARP_DMA_MAX_CHUNK) ? remaining : `ARP_DMA_MAX_CHUNK;

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         size   <= '0;
         offset <= '0;
      end else begin
         // Size lags the port by one cycle
         size <= cfg_size;
         // New size or transfer done restarts at zero
         if ((cfg_size != size) || (offset == size)) begin
            offset <= '0;
         end else if (chunk_taken) begin
            offset <= offset + chunk_len;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/packet_counters.sv
// Input and output packet counters with a sticky overflow flag in bit 31
`timescale 1ns/100ps
`default_nettype none

module packet_counters (
   input  logic        axis_aclk,
   input  logic        axis_resetn,
   input  logic        counters_clear,
   input  logic        in_eop,
   input  logic        out_eop,
   output logic [31:0] pkt_in_count,
   output logic [31:0] pkt_out_count
);

   // Low 31 bits wrap, the carry out sets bit 31 for good
   function automatic logic [31:0] bump(input logic [31:0] cnt, input logic inc);
      logic [30:0] low;
      logic        carry;
      {carry, low} = {1'b0, cnt[30:0]} + {31'd0, inc};
      return {cnt[31] | carry, low};
   endfunction

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         pkt_in_count  <= '0;
         pkt_out_count <= '0;
      end else if (counters_clear) begin
         pkt_in_count  <= '0;
         pkt_out_count <= '0;
      end else begin
         pkt_in_count  <= bump(pkt_in_count, in_eop);
         pkt_out_count <= bump(pkt_out_count, out_eop);
      end
   end

endmodule

`default_nettype wire

//--- design/packet_fifo.sv
// Fall-through beat FIFO on a register array, used as the input queue and the DMA buffer
`timescale 1ns/100ps
`default_nettype none

`include "arp_dma_macros.svh"

module packet_fifo import arp_dma_pkg::*; #(
   parameter int depth_bits = `ARP_DMA_FIFO_DEPTH_BITS
) (
   input  logic     axis_aclk,
   input  logic     axis_resetn,
   axis_beat_if.snk wr,
   axis_beat_if.src rd,
   output logic     nearly_full
);

   localparam logic [depth_bits:0] full_count = {1'b1, {depth_bits{1'b0}}};

   axis_beat_t mem [2**depth_bits];

   logic [depth_bits-1:0] wr_ptr;
   logic [depth_bits-1:0] rd_ptr;
   logic [depth_bits:0]   count;
   logic [depth_bits:0]   free_slots;
   logic                  do_wr;
   logic                  do_rd;

   assign do_wr = wr.valid & wr.ready;
   assign do_rd = rd.valid & rd.ready;

   assign wr.ready = (count != full_count);
   assign rd.valid = (count != '0);
   // Head beat shows without a read strobe
   assign rd.beat  = mem[rd_ptr];

   assign free_slots  = full_count - count;
   assign nearly_full = (free_slots <= `ARP_DMA_NEARLY_FULL_GAP);

   always_ff @(posedge axis_aclk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr.beat;
      end
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- include/arp_dma_macros.svh
// Widths, depths and protocol constants for the ARP/DMA stream steering block; include where needed
`ifndef ARP_DMA_MACROS_SVH
`define ARP_DMA_MACROS_SVH

// Stream beat geometry
`define ARP_DMA_DATA_W 256
`define ARP_DMA_KEEP_W 32
`define ARP_DMA_USER_W 128

// Beat FIFO sizing, 64 entries
`define ARP_DMA_FIFO_DEPTH_BITS 6
`define ARP_DMA_NEARLY_FULL_GAP 4

// Host DMA source ports 0x02, 0x08, 0x20 and 0x80
`define ARP_DMA_PORT_MASK 8'hAA

// Ethertype as it sits in the first beat, byte swapped
`define ARP_DMA_ETHERTYPE_ARP 16'h0608

// Metadata beat marker
`define ARP_DMA_MAGIC 32'hA5A5A5A5

// 1500 byte frame minus the 64 byte header
`define ARP_DMA_MAX_CHUNK 32'd1436
`define ARP_DMA_HDR_BYTES 32'd64

`endif

//--- tb/arp_dma_props.sv
// Assertions on the top-level stream and counter ports, bound into every arp_dma_top instance
`timescale 1ns/100ps
`default_nettype none

`include "arp_dma_macros.svh"

module arp_dma_props (
   input logic                       axis_aclk,
   input logic                       axis_resetn,
   input logic                       s_axis_tready,
   input logic [`ARP_DMA_DATA_W-1:0] m_axis_tdata,
   input logic [`ARP_DMA_KEEP_W-1:0] m_axis_tkeep,
   input logic [`ARP_DMA_USER_W-1:0] m_axis_tuser,
   input logic                       m_axis_tlast,
   input logic                       m_axis_tvalid,
   input logic                       m_axis_tready,
   input logic                       counters_clear,
   input logic [31:0]                pkt_in_count
);

   logic [`ARP_DMA_DATA_W+`ARP_DMA_KEEP_W+`ARP_DMA_USER_W:0] m_word;

   assign m_word = {m_axis_tdata, m_axis_tkeep, m_axis_tuser, m_axis_tlast};

   // Nothing offered and input open right after reset
   reset_idle: assert property (@(posedge axis_aclk)
      $rose(axis_resetn) |-> (!m_axis_tvalid && s_axis_tready))
      else $error("Output valid or input ready wrong in the first cycle after reset");

   // Stalled output beat must hold
   hold_beat: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
      (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_word)))
      else $error("Output beat changed or valid dropped while the sink was stalled");

   in_count_grows: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
      !counters_clear |=> (pkt_in_count >= $past(pkt_in_count)))
      else $error("Input packet count went down without a clear");

endmodule

bind arp_dma_top arp_dma_props arp_dma_props_i (
   .axis_aclk      (axis_aclk),
   .axis_resetn    (axis_resetn),
   .s_axis_tready  (s_axis_tready),
   .m_axis_tdata   (m_axis_tdata),
   .m_axis_tkeep   (m_axis_tkeep),
   .m_axis_tuser   (m_axis_tuser),
   .m_axis_tlast   (m_axis_tlast),
   .m_axis_tvalid  (m_axis_tvalid),
   .m_axis_tready  (m_axis_tready),
   .counters_clear (counters_clear),
   .pkt_in_count   (pkt_in_count)
);

`default_nettype wire

//--- tb/arp_dma_tb.sv
// Directed testbench for the ARP/DMA steering block; top module arp_dma_tb, compile with vlog.f
`timescale 1ns/100ps
`default_nettype none

`include "arp_dma_macros.svh"

module arp_dma_tb import arp_dma_pkg::*; ();

   localparam int wait_limit = 1000;

   logic                       axis_aclk;
   logic                       axis_resetn;
   logic [`ARP_DMA_DATA_W-1:0] s_axis_tdata;
   logic [`ARP_DMA_KEEP_W-1:0] s_axis_tkeep;
   logic [`ARP_DMA_USER_W-1:0] s_axis_tuser;
   logic                       s_axis_tvalid;
   logic                       s_axis_tready;
   logic                       s_axis_tlast;
   logic [`ARP_DMA_DATA_W-1:0] m_axis_tdata;
   logic [`ARP_DMA_KEEP_W-1:0] m_axis_tkeep;
   logic [`ARP_DMA_USER_W-1:0] m_axis_tuser;
   logic                       m_axis_tvalid;
   logic                       m_axis_tready;
   logic                       m_axis_tlast;
   logic [31:0]                cfg_size;
   logic                       counters_clear;
   logic [31:0]                pkt_in_count;
   logic [31:0]                pkt_out_count;

   logic [15:0] bp_lfsr;
   logic [31:0] exp_in;
   logic [31:0] exp_out;
   int          value_errors;
   int          wait_errors;

   // Beats to send, expected, observed, and the model of the DMA buffer
   axis_beat_t tx_q[$];
   axis_beat_t exp_q[$];
   axis_beat_t out_q[$];
   axis_beat_t seen_q[$];
   axis_beat_t dma_model[$];

   arp_dma_top arp_dma_top_i (
      .axis_aclk      (axis_aclk),
      .axis_resetn    (axis_resetn),
      .s_axis_tdata   (s_axis_tdata),
      .s_axis_tkeep   (s_axis_tkeep),
      .s_axis_tuser   (s_axis_tuser),
      .s_axis_tvalid  (s_axis_tvalid),
      .s_axis_tready  (s_axis_tready),
      .s_axis_tlast   (s_axis_tlast),
      .m_axis_tdata   (m_axis_tdata),
      .m_axis_tkeep   (m_axis_tkeep),
      .m_axis_tuser   (m_axis_tuser),
      .m_axis_tvalid  (m_axis_tvalid),
      .m_axis_tready  (m_axis_tready),
      .m_axis_tlast   (m_axis_tlast),
      .cfg_size       (cfg_size),
      .counters_clear (counters_clear),
      .pkt_in_count   (pkt_in_count),
      .pkt_out_count  (pkt_out_count)
   );

   initial axis_aclk = 1'b0;
   always #5 axis_aclk = ~axis_aclk;

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // One LFSR bit per cycle for output back-pressure
   always @(posedge axis_aclk) begin
      bp_lfsr       <= lfsr_next(bp_lfsr);
      m_axis_tready <= bp_lfsr[0];
   end

   // Beats are stable from the falling edge up to the transfer edge
   always @(negedge axis_aclk) begin
      if (axis_resetn === 1'b1 && m_axis_tvalid === 1'b1 && m_axis_tready === 1'b1) begin
         out_q.push_back({m_axis_tdata, m_axis_tkeep, m_axis_tuser, m_axis_tlast});
      end
   end

   task automatic check_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_user(input string name, input tuser_u got, input tuser_u exp);
      if (got !== exp) begin
         value_errors++;
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got.raw, exp.raw);
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         value_errors++;
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // Word k of beat idx is {tag, 5A, k, idx}, so bits 111:96 never read as ARP
   function automatic axis_beat_t make_beat(input logic [7:0] tag, input int idx,
                                            input logic [7:0] port, input logic last);
      axis_beat_t b;
      tuser_u     u;
      int         k;
      for (k = 0; k < 8; k++) begin
         b.data[32*k +: 32] = {tag, 8'h5A, 8'(k), 8'(idx)};
      end
      b.keep             = last ? 32'h00FF_FFFF : 32'hFFFF_FFFF;
      u.raw              = '0;
      u.fields.spare     = {13{tag}};
      u.fields.src_port  = port;
      u.fields.len       = 16'd200 + 16'(idx);
      b.user             = u.raw;
      b.last             = last;
      return b;
   endfunction

   task automatic send_queued_beats();
      axis_beat_t b;
      int         n;
      while (tx_q.size() > 0) begin
         b = tx_q.pop_front();
         @(posedge axis_aclk);
         s_axis_tvalid <= 1'b1;
         s_axis_tdata  <= b.data;
         s_axis_tkeep  <= b.keep;
         s_axis_tuser  <= b.user;
         s_axis_tlast  <= b.last;
         n = 0;
         @(negedge axis_aclk);
         while (!s_axis_tready && n < wait_limit) begin
            n++;
            @(negedge axis_aclk);
         end
         if (!s_axis_tready) begin
            wait_errors++;
            $display("Input beat not accepted within %0d cycles at %0t", wait_limit, $time);
         end
      end
      @(posedge axis_aclk);
      s_axis_tvalid <= 1'b0;
   endtask

   task automatic wait_for_beats(input int n);
      int cycles;
      cycles = 0;
      while (out_q.size() < n && cycles < wait_limit) begin
         @(posedge axis_aclk);
         cycles++;
      end
      if (out_q.size() < n) begin
         wait_errors++;
         $display("Only %0d of %0d output beats arrived by %0t", out_q.size(), n, $time);
      end
   endtask

   task automatic compare_beats(input string what);
      axis_beat_t exp;
      int         idx;
      idx = 0;
      seen_q.delete();
      while (exp_q.size() > 0 && out_q.size() > 0) begin
         exp = exp_q.pop_front();
         seen_q.push_back(out_q.pop_front());
         check_beat($sformatf("%s beat %0d", what, idx), seen_q[idx], exp);
         idx++;
      end
      exp_q.delete();
   endtask

   // Counters move on the transfer edge of a last beat
   task automatic confirm_counters(input string what);
      repeat (2) @(posedge axis_aclk);
      @(negedge axis_aclk);
      check_word({what, " pkt_in_count"}, pkt_in_count, exp_in);
      check_word({what, " pkt_out_count"}, pkt_out_count, exp_out);
      check_word({what, " stray output beats"}, 32'(out_q.size()), 32'd0);
   endtask

   task automatic absorb_dma_packet(input logic [7:0] tag);
      axis_beat_t b;
      int         i;
      for (i = 0; i < 2; i++) begin
         b = make_beat(tag, i, 8'h08, i == 1);
         tx_q.push_back(b);
         dma_model.push_back(b);
      end
      exp_in = exp_in + 1;
      send_queued_beats();
   endtask

   // Three beat ARP request; a served one returns header, metadata and a DMA packet
   task automatic run_arp_request(input logic [7:0] tag, input bit served,
                                  input logic [15:0] exp_len, input logic [31:0] exp_offset);
      axis_beat_t arp[3];
      axis_beat_t b;
      tuser_u     exp_user;
      tuser_u     got_user;
      tdata_u     meta;
      int         i;
      int         n_exp;
      for (i = 0; i < 3; i++) begin
         arp[i] = make_beat(tag, i, 8'h01, i == 2);
      end
      arp[0].data[111:96] = `ARP_DMA_ETHERTYPE_ARP;
      for (i = 0; i < 3; i++) begin
         tx_q.push_back(arp[i]);
      end
      if (served) begin
         exp_user.raw         = arp[0].user;
         exp_user.fields.len  = exp_len;
         b                    = arp[0];
         b.user               = exp_user.raw;
         exp_q.push_back(b);
         meta.raw             = '0;
         meta.meta.arp_tail   = arp[1].data[79:0];
         meta.meta.magic      = `ARP_DMA_MAGIC;
         meta.meta.offset     = exp_offset;
         meta.meta.size       = cfg_size;
         b.data               = meta.raw;
         b.keep               = '1;
         b.user               = '0;
         b.last               = 1'b0;
         exp_q.push_back(b);
         while (dma_model.size() > 0) begin
            b = dma_model.pop_front();
            exp_q.push_back(b);
            if (b.last) begin
               break;
            end
         end
      end else begin
         for (i = 0; i < 3; i++) begin
            exp_q.push_back(arp[i]);
         end
      end
      exp_in  = exp_in + 1;
      exp_out = exp_out + 1;
      n_exp   = exp_q.size();
      send_queued_beats();
      wait_for_beats(n_exp);
      compare_beats($sformatf("ARP %h", tag));
      if (served && seen_q.size() >= 2) begin
         got_user.raw = seen_q[0].user;
         check_user("ARP first beat tuser", got_user, exp_user);
         meta.raw = seen_q[1].data;
         check_word("metadata offset", meta.meta.offset, exp_offset);
         check_word("metadata size", meta.meta.size, cfg_size);
      end
   endtask

   task automatic reset_values();
      @(negedge axis_aclk);
      check_word("m_axis_tvalid", 32'(m_axis_tvalid), 32'd0);
      check_word("s_axis_tready", 32'(s_axis_tready), 32'd1);
      check_word("pkt_in_count", pkt_in_count, 32'd0);
      check_word("pkt_out_count", pkt_out_count, 32'd0);
   endtask

   task automatic pass_through();
      int i;
      for (i = 0; i < 3; i++) begin
         tx_q.push_back(make_beat(8'h11, i, 8'h01, i == 2));
         exp_q.push_back(make_beat(8'h11, i, 8'h01, i == 2));
      end
      exp_in  = exp_in + 1;
      exp_out = exp_out + 1;
      send_queued_beats();
      wait_for_beats(3);
      compare_beats("pass-through");
      confirm_counters("pass-through");
   endtask

   task automatic dma_absorb();
      absorb_dma_packet(8'h33);
      // Absorbed packets must stay silent
      repeat (50) @(posedge axis_aclk);
      check_word("output beats during DMA absorb", 32'(out_q.size()), 32'd0);
      confirm_counters("DMA absorb");
   endtask

   task automatic served_arp();
      @(posedge axis_aclk);
      cfg_size <= 32'd2000;
      repeat (2) @(posedge axis_aclk);
      absorb_dma_packet(8'h41);
      run_arp_request(8'h42, 1'b1, 16'd1500, 32'd0);
      absorb_dma_packet(8'h43);
      run_arp_request(8'h44, 1'b1, 16'd628, 32'd1436);
      // Offset reached the size, so it starts over
      absorb_dma_packet(8'h45);
      run_arp_request(8'h46, 1'b1, 16'd1500, 32'd0);
      confirm_counters("served ARP");
   endtask

   task automatic unserved_arp_and_clear();
      // One stored DMA packet is still waiting
      run_arp_request(8'h51, 1'b1, 16'd628, 32'd1436);
      run_arp_request(8'h52, 1'b0, 16'd0, 32'd0);
      confirm_counters("unserved ARP");
      @(posedge axis_aclk);
      counters_clear <= 1'b1;
      @(posedge axis_aclk);
      counters_clear <= 1'b0;
      exp_in  = '0;
      exp_out = '0;
      @(negedge axis_aclk);
      check_word("cleared pkt_in_count", pkt_in_count, exp_in);
      check_word("cleared pkt_out_count", pkt_out_count, exp_out);
   endtask

   initial begin
      bp_lfsr        = 16'd7889;
      exp_in         = '0;
      exp_out        = '0;
      value_errors   = 0;
      wait_errors    = 0;
      axis_resetn    <= 1'b0;
      s_axis_tdata   <= '0;
      s_axis_tkeep   <= '0;
      s_axis_tuser   <= '0;
      s_axis_tvalid  <= 1'b0;
      s_axis_tlast   <= 1'b0;
      m_axis_tready  <= 1'b0;
      cfg_size       <= '0;
      counters_clear <= 1'b0;
      repeat (2) @(posedge axis_aclk);
      axis_resetn <= 1'b1;
      reset_values();
      pass_through();
      dma_absorb();
      served_arp();
      unserved_arp_and_clear();
      $display("Errors: %0d value mismatches, %0d timeouts", value_errors, wait_errors);
      if (value_errors == 0 && wait_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Hard stop in case a wait loop never returns
   initial begin
      #200000;
      $display("Simulation time limit reached before the tests finished");
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
design/arp_dma_pkg.sv
design/axis_beat_if.sv
design/packet_fifo.sv
design/chunk_tracker.sv
design/arp_dma_steer.sv
design/packet_counters.sv
design/arp_dma_top.sv
tb/arp_dma_props.sv
tb/arp_dma_tb.sv
